// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := dma_rd_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG); grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
rtl/dma_rd_pkg.sv
rtl/word_mem.sv
rtl/mem_rd_arbiter.sv
rtl/mm2s_reader.sv
rtl/rdata_realign.sv
rtl/dma_rd_top.sv
verif/tb_clk_gen.sv
verif/dma_rd_sva.sv
verif/dma_rd_tb.sv

// ==== rtl/dma_rd_pkg.sv ====
`default_nettype none

package dma_rd_pkg;

	// stream and memory word
	localparam int DATA_W = 32;
	localparam int KEEP_W = DATA_W / 8;
	localparam int OFS_W = $clog2(KEEP_W);

	// word memory geometry
	localparam int MEM_DEPTH = 256;
	localparam int WADDR_W = $clog2(MEM_DEPTH);
	localparam int BADDR_W = WADDR_W + OFS_W;

	// command length in bytes, 1 to 64
	localparam int LEN_W = 7;

	// number of read channels
	localparam int N_CH = 2;

	// reader command engine states
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_REQ,
		RD_WAIT,
		RD_SEND
	} rd_state_e;

endpackage

`default_nettype wire

// ==== rtl/dma_rd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_rd_top (
	input  wire                                                 axis_aclk,
	input  wire                                                 axis_aresetn,
	input  wire                                                 mem_wr_en_i,
	input  wire [dma_rd_pkg::WADDR_W-1:0]                       mem_wr_addr_i,
	input  wire [dma_rd_pkg::DATA_W-1:0]                        mem_wr_data_i,
	input  wire [dma_rd_pkg::N_CH-1:0]                          cmd_valid_i,
	input  wire [dma_rd_pkg::N_CH-1:0][dma_rd_pkg::BADDR_W-1:0] cmd_addr_i,
	input  wire [dma_rd_pkg::N_CH-1:0][dma_rd_pkg::LEN_W-1:0]   cmd_len_i,
	output wire [dma_rd_pkg::N_CH-1:0]                          busy_o,
	output wire [dma_rd_pkg::N_CH-1:0][dma_rd_pkg::DATA_W-1:0]  m_data_o,
	output wire [dma_rd_pkg::N_CH-1:0][dma_rd_pkg::KEEP_W-1:0]  m_keep_o,
	output wire [dma_rd_pkg::N_CH-1:0]                          m_last_o,
	output wire [dma_rd_pkg::N_CH-1:0]                          m_valid_o,
	input  wire [dma_rd_pkg::N_CH-1:0]                          m_ready_i
);
	import dma_rd_pkg::*;

	wire mem_rd_en;
	wire [WADDR_W-1:0] mem_rd_addr;
	wire [DATA_W-1:0] mem_rd_data;
	wire [N_CH-1:0] rd_req;
	wire [N_CH-1:0] rd_gnt;
	wire [N_CH-1:0] rd_rvalid;
	wire [N_CH-1:0][WADDR_W-1:0] rd_addr;
	wire [DATA_W-1:0] rd_rdata;
	wire [N_CH-1:0][DATA_W-1:0] s_data;
	wire [N_CH-1:0][KEEP_W-1:0] s_keep;
	wire [N_CH-1:0] s_last;
	wire [N_CH-1:0] s_valid;
	wire [N_CH-1:0] s_ready;
	wire [N_CH-1:0] pkt_done;

	// end of packet seen at the stream output
	assign pkt_done = m_valid_o & m_ready_i & m_last_o;

	word_mem mem_i (
		.axis_aclk(axis_aclk), .wr_en_i(mem_wr_en_i),
		.wr_addr_i(mem_wr_addr_i), .wr_data_i(mem_wr_data_i),
		.rd_en_i(mem_rd_en), .rd_addr_i(mem_rd_addr), .rd_data_o(mem_rd_data)
	);

	mem_rd_arbiter arb_i (
		.axis_aclk(axis_aclk), .axis_aresetn(axis_aresetn),
		.req_i(rd_req), .addr0_i(rd_addr[0]), .addr1_i(rd_addr[1]), .gnt_o(rd_gnt),
		.mem_rd_en_o(mem_rd_en), .mem_rd_addr_o(mem_rd_addr), .mem_rd_data_i(mem_rd_data),
		.rvalid_o(rd_rvalid), .rdata_o(rd_rdata)
	);

	if (1) begin : ch0
		mm2s_reader reader_i (
			.axis_aclk(axis_aclk), .axis_aresetn(axis_aresetn),
			.cmd_valid_i(cmd_valid_i[0]), .cmd_addr_i(cmd_addr_i[0]),
			.cmd_len_i(cmd_len_i[0]), .busy_o(busy_o[0]),
			.rd_req_o(rd_req[0]), .rd_addr_o(rd_addr[0]), .rd_gnt_i(rd_gnt[0]),
			.rd_rvalid_i(rd_rvalid[0]), .rd_rdata_i(rd_rdata),
			.m_data_o(s_data[0]), .m_keep_o(s_keep[0]), .m_last_o(s_last[0]),
			.m_valid_o(s_valid[0]), .m_ready_i(s_ready[0]), .pkt_done_i(pkt_done[0])
		);
		rdata_realign realign_i (
			.axis_aclk(axis_aclk), .axis_aresetn(axis_aresetn),
			.s_data_i(s_data[0]), .s_keep_i(s_keep[0]), .s_last_i(s_last[0]),
			.s_valid_i(s_valid[0]), .s_ready_o(s_ready[0]),
			.m_data_o(m_data_o[0]), .m_keep_o(m_keep_o[0]), .m_last_o(m_last_o[0]),
			.m_valid_o(m_valid_o[0]), .m_ready_i(m_ready_i[0])
		);
	end

	if (1) begin : ch1
		mm2s_reader reader_i (
			.axis_aclk(axis_aclk), .axis_aresetn(axis_aresetn),
			.cmd_valid_i(cmd_valid_i[1]), .cmd_addr_i(cmd_addr_i[1]),
			.cmd_len_i(cmd_len_i[1]), .busy_o(busy_o[1]),
			.rd_req_o(rd_req[1]), .rd_addr_o(rd_addr[1]), .rd_gnt_i(rd_gnt[1]),
			.rd_rvalid_i(rd_rvalid[1]), .rd_rdata_i(rd_rdata),
			.m_data_o(s_data[1]), .m_keep_o(s_keep[1]), .m_last_o(s_last[1]),
			.m_valid_o(s_valid[1]), .m_ready_i(s_ready[1]), .pkt_done_i(pkt_done[1])
		);
		rdata_realign realign_i (
			.axis_aclk(axis_aclk), .axis_aresetn(axis_aresetn),
			.s_data_i(s_data[1]), .s_keep_i(s_keep[1]), .s_last_i(s_last[1]),
			.s_valid_i(s_valid[1]), .s_ready_o(s_ready[1]),
			.m_data_o(m_data_o[1]), .m_keep_o(m_keep_o[1]), .m_last_o(m_last_o[1]),
			.m_valid_o(m_valid_o[1]), .m_ready_i(m_ready_i[1])
		);
	end

endmodule

`default_nettype wire

// ==== rtl/mem_rd_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_rd_arbiter (
	input  wire                            axis_aclk,
	input  wire                            axis_aresetn,
	input  wire [dma_rd_pkg::N_CH-1:0]     req_i,
	input  wire [dma_rd_pkg::WADDR_W-1:0]  addr0_i,
	input  wire [dma_rd_pkg::WADDR_W-1:0]  addr1_i,
	output logic [dma_rd_pkg::N_CH-1:0]    gnt_o,
	output logic                           mem_rd_en_o,
	output logic [dma_rd_pkg::WADDR_W-1:0] mem_rd_addr_o,
	input  wire [dma_rd_pkg::DATA_W-1:0]   mem_rd_data_i,
	output logic [dma_rd_pkg::N_CH-1:0]    rvalid_o,
	output logic [dma_rd_pkg::DATA_W-1:0]  rdata_o
);

	// channel that wins a tie
	logic prio;
	// owner of the read in flight
	logic tag;
	logic pend;

	assign gnt_o[0] = req_i[0] & (~req_i[1] | ~prio);
	assign gnt_o[1] = req_i[1] & (~req_i[0] | prio);

	assign mem_rd_en_o = |gnt_o;
	assign mem_rd_addr_o = gnt_o[1] ? addr1_i : addr0_i;

	always_ff @(posedge axis_aclk or negedge axis_aresetn)
	begin
		if (!axis_aresetn)
		begin
			prio <= 1'b0;
			tag <= 1'b0;
			pend <= 1'b0;
		end
		else
		begin
			pend <= mem_rd_en_o;
			if (mem_rd_en_o)
			begin
				tag <= gnt_o[1];
				// other channel goes first next time
				prio <= ~gnt_o[1];
			end
		end
	end

	// memory data lines up with pend
	assign rvalid_o[0] = pend & ~tag;
	assign rvalid_o[1] = pend & tag;
	assign rdata_o = mem_rd_data_i;

endmodule

`default_nettype wire

// ==== rtl/mm2s_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module mm2s_reader (
	input  wire                            axis_aclk,
	input  wire                            axis_aresetn,
	input  wire                            cmd_valid_i,
	input  wire [dma_rd_pkg::BADDR_W-1:0]  cmd_addr_i,
	input  wire [dma_rd_pkg::LEN_W-1:0]    cmd_len_i,
	output logic                           busy_o,
	output logic                           rd_req_o,
	output logic [dma_rd_pkg::WADDR_W-1:0] rd_addr_o,
	input  wire                            rd_gnt_i,
	input  wire                            rd_rvalid_i,
	input  wire [dma_rd_pkg::DATA_W-1:0]   rd_rdata_i,
	output logic [dma_rd_pkg::DATA_W-1:0]  m_data_o,
	output logic [dma_rd_pkg::KEEP_W-1:0]  m_keep_o,
	output logic                           m_last_o,
	output logic                           m_valid_o,
	input  wire                            m_ready_i,
	input  wire                            pkt_done_i
);
	import dma_rd_pkg::*;

	rd_state_e state;
	logic [WADDR_W-1:0] word_addr;
	logic [WADDR_W-1:0] end_word;
	logic [OFS_W-1:0] start_ofs;
	logic [OFS_W-1:0] end_ofs;
	logic first_word;
	logic last_word;
	logic cmd_take;
	logic [BADDR_W-1:0] end_baddr;
	logic [KEEP_W-1:0] lo_mask;
	logic [KEEP_W-1:0] hi_mask;

	assign cmd_take = cmd_valid_i & ~busy_o;
	// byte address of the final byte
	assign end_baddr = cmd_addr_i + BADDR_W'(cmd_len_i) - BADDR_W'(1);
	assign last_word = (word_addr == end_word);

	// drop lanes before start and after end
	assign lo_mask = first_word ? ({KEEP_W{1'b1}} << start_ofs) : {KEEP_W{1'b1}};
	assign hi_mask = last_word ? ({KEEP_W{1'b1}} >> (OFS_W'(KEEP_W - 1) - end_ofs)) :
		{KEEP_W{1'b1}};

	always_ff @(posedge axis_aclk or negedge axis_aresetn)
	begin
		if (!axis_aresetn)
		begin
			state <= RD_IDLE;
			busy_o <= 1'b0;
		end
		else
		begin
			if (cmd_take)
				busy_o <= 1'b1;
			else if (pkt_done_i)
				busy_o <= 1'b0;
			case (state)
				RD_IDLE:
					if (cmd_take)
						state <= RD_REQ;
				RD_REQ:
					if (rd_gnt_i)
						state <= RD_WAIT;
				RD_WAIT:
					if (rd_rvalid_i)
						state <= RD_SEND;
				RD_SEND:
					if (m_ready_i)
						state <= last_word ? RD_IDLE : RD_REQ;
				default:
					state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge axis_aclk)
	begin
		if (cmd_take)
		begin
			word_addr <= cmd_addr_i[BADDR_W-1:OFS_W];
			end_word <= end_baddr[BADDR_W-1:OFS_W];
			start_ofs <= cmd_addr_i[OFS_W-1:0];
			end_ofs <= end_baddr[OFS_W-1:0];
			first_word <= 1'b1;
		end
		else if (state == RD_SEND && m_ready_i)
		begin
			word_addr <= word_addr + 1'b1;
			first_word <= 1'b0;
		end
		// hold returned word until the stream takes it
		if (state == RD_WAIT && rd_rvalid_i)
			m_data_o <= rd_rdata_i;
	end

	assign rd_req_o = (state == RD_REQ);
	assign rd_addr_o = word_addr;
	assign m_valid_o = (state == RD_SEND);
	assign m_last_o = last_word;
	assign m_keep_o = lo_mask & hi_mask;

endmodule

`default_nettype wire

// ==== rtl/rdata_realign.sv ====
`timescale 1ns/1ps
`default_nettype none

module rdata_realign (
	input  wire                            axis_aclk,
	input  wire                            axis_aresetn,
	input  wire [dma_rd_pkg::DATA_W-1:0]   s_data_i,
	input  wire [dma_rd_pkg::KEEP_W-1:0]   s_keep_i,
	input  wire                            s_last_i,
	input  wire                            s_valid_i,
	output logic                           s_ready_o,
	output logic [dma_rd_pkg::DATA_W-1:0]  m_data_o,
	output logic [dma_rd_pkg::KEEP_W-1:0]  m_keep_o,
	output logic                           m_last_o,
	output logic                           m_valid_o,
	input  wire                            m_ready_i
);
	import dma_rd_pkg::*;

	logic first_beat;
	logic flush;
	logic [OFS_W-1:0] shift;
	logic [OFS_W-1:0] shift_nxt;
	logic [KEEP_W-1:0] first_keep;
	logic [DATA_W-1:0] merge_data;
	logic [KEEP_W-1:0] merge_keep;
	logic one_beat;
	logic leftover;
	logic s_fire;
	logic stage_ready;
	logic pre_valid;
	logic pre_last;
	logic [DATA_W-1:0] pre_data;
	logic [KEEP_W-1:0] pre_keep;

	// leading empty lanes of the incoming beat
	always_comb
	begin
		shift_nxt = '0;
		for (int i = KEEP_W - 1; i >= 0; i--)
		begin
			if (s_keep_i[i])
				shift_nxt = OFS_W'(i);
		end
	end

	assign stage_ready = ~m_valid_o | m_ready_i;
	assign s_ready_o = ~flush & stage_ready;
	assign s_fire = s_valid_i & s_ready_o;
	assign one_beat = first_beat & s_last_i & ~flush;
	// last word still has bytes past the merge beat
	assign leftover = |(s_keep_i & first_keep);

	always_comb
	begin
		if (flush)
		begin
			pre_data = merge_data >> (shift * 8);
			pre_keep = merge_keep >> shift;
		end
		else if (one_beat)
		begin
			pre_data = s_data_i >> (shift_nxt * 8);
			pre_keep = s_keep_i >> shift_nxt;
		end
		else
		begin
			// upper bytes of held beat, lower bytes of current
			pre_data = (merge_data >> (shift * 8)) | (s_data_i << (DATA_W - shift * 8));
			pre_keep = (merge_keep >> shift) | (s_keep_i << (KEEP_W - shift));
		end
	end

	// first beat of a longer packet only fills the buffer
	assign pre_valid = flush | (s_valid_i & (s_last_i | ~first_beat));
	assign pre_last = flush | (s_last_i & (first_beat | ~leftover));

	always_ff @(posedge axis_aclk or negedge axis_aresetn)
	begin
		if (!axis_aresetn)
		begin
			first_beat <= 1'b1;
			flush <= 1'b0;
		end
		else
		begin
			if (s_fire)
				first_beat <= s_last_i;
			if (flush)
				flush <= ~stage_ready;
			else
				flush <= s_fire & ~first_beat & s_last_i & leftover;
		end
	end

	always_ff @(posedge axis_aclk)
	begin
		if (s_fire && first_beat)
		begin
			shift <= shift_nxt;
			first_keep <= s_keep_i;
		end
		if (s_fire)
		begin
			merge_data <= s_data_i;
			merge_keep <= s_keep_i;
		end
	end

	// forward registered output stage
	always_ff @(posedge axis_aclk or negedge axis_aresetn)
	begin
		if (!axis_aresetn)
			m_valid_o <= 1'b0;
		else if (stage_ready)
			m_valid_o <= pre_valid;
	end

	always_ff @(posedge axis_aclk)
	begin
		if (stage_ready && pre_valid)
		begin
			m_data_o <= pre_data;
			m_keep_o <= pre_keep;
			m_last_o <= pre_last;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/word_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_mem (
	input  wire                            axis_aclk,
	input  wire                            wr_en_i,
	input  wire [dma_rd_pkg::WADDR_W-1:0]  wr_addr_i,
	input  wire [dma_rd_pkg::DATA_W-1:0]   wr_data_i,
	input  wire                            rd_en_i,
	input  wire [dma_rd_pkg::WADDR_W-1:0]  rd_addr_i,
	output logic [dma_rd_pkg::DATA_W-1:0]  rd_data_o
);
	import dma_rd_pkg::*;

	logic [DATA_W-1:0] mem [MEM_DEPTH];

	// external preload port
	always_ff @(posedge axis_aclk)
	begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// registered read, data one cycle after rd_en_i
	always_ff @(posedge axis_aclk)
	begin
		if (rd_en_i)
			rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

// ==== verif/dma_rd_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_rd_sva (
	input wire                           axis_aclk,
	input wire                           axis_aresetn,
	input wire [dma_rd_pkg::DATA_W-1:0]  m_data_i,
	input wire [dma_rd_pkg::KEEP_W-1:0]  m_keep_i,
	input wire                           m_last_i,
	input wire                           m_valid_i,
	input wire                           m_ready_i
);

	// stalled beat keeps valid
	a_hold_valid: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
		m_valid_i && !m_ready_i |=> m_valid_i)
		else $error("realign output valid dropped while stalled");

	// stalled beat keeps its payload
	a_hold_data: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
		m_valid_i && !m_ready_i |=> $stable(m_data_i) && $stable(m_keep_i) && $stable(m_last_i))
		else $error("realign output payload changed while stalled");

	// keep is nonzero and packed from lane 0
	a_keep_packed: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
		m_valid_i |-> (m_keep_i != '0) && (((m_keep_i + 1'b1) & m_keep_i) == '0))
		else $error("realign output keep not contiguous from lane 0");

	a_idle_in_reset: assert property (@(posedge axis_aclk) !axis_aresetn |-> !m_valid_i)
		else $error("realign output valid during reset");

endmodule

bind rdata_realign dma_rd_sva sva_i (
	.axis_aclk(axis_aclk),
	.axis_aresetn(axis_aresetn),
	.m_data_i(m_data_o),
	.m_keep_i(m_keep_o),
	.m_last_i(m_last_o),
	.m_valid_i(m_valid_o),
	.m_ready_i(m_ready_i)
);

`default_nettype wire

// ==== verif/dma_rd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_rd_tb;
	import dma_rd_pkg::*;

	typedef struct packed {
		logic [N_CH-1:0] mask;
		logic [BADDR_W-1:0] addr0;
		logic [LEN_W-1:0] len0;
		logic [BADDR_W-1:0] addr1;
		logic [LEN_W-1:0] len1;
		logic rnd_ready;
	} test_t;

	localparam int N_TESTS = 20;
	localparam logic [15:0] LFSR_SEED = 16'd17813;

	// channel mask, ch0 addr/len, ch1 addr/len, random ready
	test_t tests [N_TESTS] = '{
		'{2'b01, 10'd0, 7'd16, 10'd0, 7'd0, 1'b0},
		'{2'b10, 10'd0, 7'd0, 10'd64, 7'd64, 1'b0},
		'{2'b01, 10'd128, 7'd4, 10'd0, 7'd0, 1'b0},
		'{2'b01, 10'd201, 7'd8, 10'd0, 7'd0, 1'b0},
		'{2'b10, 10'd0, 7'd0, 10'd302, 7'd13, 1'b0},
		'{2'b01, 10'd403, 7'd7, 10'd0, 7'd0, 1'b0},
		'{2'b10, 10'd0, 7'd0, 10'd506, 7'd30, 1'b0},
		'{2'b01, 10'd607, 7'd64, 10'd0, 7'd0, 1'b0},
		// single beats, every offset and length 1 to 4
		'{2'b11, 10'd700, 7'd1, 10'd704, 7'd2, 1'b0},
		'{2'b11, 10'd708, 7'd3, 10'd712, 7'd4, 1'b0},
		'{2'b11, 10'd717, 7'd1, 10'd721, 7'd2, 1'b0},
		'{2'b11, 10'd725, 7'd3, 10'd729, 7'd4, 1'b1},
		'{2'b11, 10'd734, 7'd1, 10'd738, 7'd2, 1'b0},
		'{2'b11, 10'd742, 7'd3, 10'd746, 7'd4, 1'b0},
		'{2'b11, 10'd751, 7'd1, 10'd755, 7'd2, 1'b0},
		'{2'b11, 10'd759, 7'd3, 10'd763, 7'd4, 1'b1},
		// both channels over shared bytes
		'{2'b11, 10'd100, 7'd50, 10'd102, 7'd45, 1'b0},
		'{2'b11, 10'd5, 7'd63, 10'd9, 7'd60, 1'b1},
		'{2'b11, 10'd850, 7'd33, 10'd851, 7'd64, 1'b1},
		'{2'b11, 10'd3, 7'd64, 10'd960, 7'd64, 1'b1}
	};

	logic clk;
	logic rst_n;
	logic mem_wr_en;
	logic [WADDR_W-1:0] mem_wr_addr;
	logic [DATA_W-1:0] mem_wr_data;
	logic [N_CH-1:0] cmd_valid;
	logic [N_CH-1:0][BADDR_W-1:0] cmd_addr;
	logic [N_CH-1:0][LEN_W-1:0] cmd_len;
	wire [N_CH-1:0] busy;
	wire [N_CH-1:0][DATA_W-1:0] m_data;
	wire [N_CH-1:0][KEEP_W-1:0] m_keep;
	wire [N_CH-1:0] m_last;
	wire [N_CH-1:0] m_valid;
	logic [N_CH-1:0] m_ready;

	logic [15:0] lfsr;
	logic [7:0] tb_mem [MEM_DEPTH*KEEP_W];
	int errors;
	int passed;

	tb_clk_gen clk_gen_i (
		.clk_o(clk),
		.rst_n_o(rst_n)
	);

	dma_rd_top dut_i (
		.axis_aclk(clk), .axis_aresetn(rst_n),
		.mem_wr_en_i(mem_wr_en), .mem_wr_addr_i(mem_wr_addr), .mem_wr_data_i(mem_wr_data),
		.cmd_valid_i(cmd_valid), .cmd_addr_i(cmd_addr), .cmd_len_i(cmd_len), .busy_o(busy),
		.m_data_o(m_data), .m_keep_o(m_keep), .m_last_o(m_last), .m_valid_o(m_valid),
		.m_ready_i(m_ready)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic rand_bit();
		logic b;
		b = lfsr[15];
		lfsr = lfsr_next(lfsr);
		return b;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		for (int i = 0; i < 8; i++)
			v[i] = rand_bit();
		return v;
	endfunction

	function automatic int ch_words(input int addr, input int len);
		return ((addr + len - 1) / KEEP_W) - (addr / KEEP_W) + 1;
	endfunction

	task automatic check_val(input string name, input int ch, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] got);
		assert (got === exp)
		else
		begin
			$display("FAIL %0t ch%0d %s expected %h actual %h", $time, ch, name, exp, got);
			errors++;
		end
	endtask

	task automatic preload_mem();
		logic [DATA_W-1:0] w;
		for (int a = 0; a < MEM_DEPTH; a++)
		begin
			for (int b = 0; b < KEEP_W; b++)
			begin
				tb_mem[a*KEEP_W+b] = rand_byte();
				w[b*8 +: 8] = tb_mem[a*KEEP_W+b];
			end
			@(posedge clk);
			mem_wr_en <= 1'b1;
			mem_wr_addr <= WADDR_W'(a);
			mem_wr_data <= w;
		end
		@(posedge clk);
		mem_wr_en <= 1'b0;
	endtask

	// expected beat is the next bytes of memory packed from lane 0
	task automatic check_beat(input int ch, input int addr, input int len, input int beat,
		output logic fin);
		int rem;
		int nb;
		logic [KEEP_W-1:0] exp_keep;
		logic [DATA_W-1:0] exp_data;
		logic [DATA_W-1:0] lane_mask;
		rem = len - beat * KEEP_W;
		nb = (rem < KEEP_W) ? rem : KEEP_W;
		exp_keep = '0;
		exp_data = '0;
		lane_mask = '0;
		for (int j = 0; j < nb; j++)
		begin
			exp_keep[j] = 1'b1;
			exp_data[j*8 +: 8] = tb_mem[addr + beat*KEEP_W + j];
			lane_mask[j*8 +: 8] = 8'hff;
		end
		fin = (rem <= KEEP_W);
		check_val("m_keep_o", ch, DATA_W'(exp_keep), DATA_W'(m_keep[ch]));
		check_val("m_last_o", ch, DATA_W'(fin), DATA_W'(m_last[ch]));
		check_val("m_data_o", ch, exp_data, m_data[ch] & lane_mask);
	endtask

	task automatic run_test(input int t);
		test_t tc;
		int addr [N_CH];
		int len [N_CH];
		int beats [N_CH];
		logic [N_CH-1:0] done;
		logic [N_CH-1:0] busy_chk;
		logic fin;
		int err_start;
		tc = tests[t];
		err_start = errors;
		addr[0] = int'(tc.addr0);
		addr[1] = int'(tc.addr1);
		len[0] = int'(tc.len0);
		len[1] = int'(tc.len1);
		beats[0] = 0;
		beats[1] = 0;
		done = ~tc.mask;
		busy_chk = '0;
		assert (busy == '0)
		else
		begin
			$display("test %0d started while a channel was still busy", t);
			errors++;
		end
		@(posedge clk);
		cmd_valid <= tc.mask;
		cmd_addr[0] <= tc.addr0;
		cmd_addr[1] <= tc.addr1;
		cmd_len[0] <= tc.len0;
		cmd_len[1] <= tc.len1;
		@(posedge clk);
		cmd_valid <= '0;
		@(posedge clk);
		for (int ch = 0; ch < N_CH; ch++)
			if (tc.mask[ch])
				check_val("busy_o", ch, DATA_W'(1), DATA_W'(busy[ch]));
		while (done != '1 || busy_chk != '0)
		begin
			@(posedge clk);
			for (int ch = 0; ch < N_CH; ch++)
			begin
				// busy drops one cycle after the last beat
				if (busy_chk[ch])
				begin
					check_val("busy_o", ch, DATA_W'(0), DATA_W'(busy[ch]));
					busy_chk[ch] = 1'b0;
				end
				// busy holds until the last beat leaves
				if (!done[ch])
					check_val("busy_o", ch, DATA_W'(1), DATA_W'(busy[ch]));
				if (!done[ch] && m_valid[ch] && m_ready[ch])
				begin
					check_beat(ch, addr[ch], len[ch], beats[ch], fin);
					beats[ch]++;
					if (fin)
					begin
						done[ch] = 1'b1;
						busy_chk[ch] = 1'b1;
					end
				end
				// no beat after the last one or on an idle channel
				else if (done[ch])
					check_val("m_valid_o", ch, DATA_W'(0), DATA_W'(m_valid[ch]));
				m_ready[ch] <= tc.rnd_ready ? rand_bit() : 1'b1;
			end
		end
		if (errors == err_start)
			passed++;
		$display("test %0d done, beats %0d/%0d, errors %0d", t, beats[0], beats[1],
			errors - err_start);
	endtask

	initial
	begin
		mem_wr_en = 1'b0;
		mem_wr_addr = '0;
		mem_wr_data = '0;
		cmd_valid = '0;
		cmd_addr = '0;
		cmd_len = '0;
		m_ready = '0;
		lfsr = LFSR_SEED;
		errors = 0;
		passed = 0;
		wait (rst_n === 1'b1);
		preload_mem();
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors", N_TESTS, passed,
			N_TESTS - passed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// budget covers reset, preload and every test
	initial
	begin
		int budget;
		budget = 10 + MEM_DEPTH + 2;
		for (int t = 0; t < N_TESTS; t++)
		begin
			budget += 40;
			if (tests[t].mask[0])
				budget += 20 * ch_words(int'(tests[t].addr0), int'(tests[t].len0));
			if (tests[t].mask[1])
				budget += 20 * ch_words(int'(tests[t].addr1), int'(tests[t].len1));
		end
		repeat (budget)
			@(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", budget);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);
	// 4 ns period
	localparam int HALF_NS = 2;
	localparam int RST_CYCLES = 10;

	initial
	begin
		clk_o = 1'b0;
		forever
			#(HALF_NS) clk_o = ~clk_o;
	end

	// reset released on a rising edge
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES)
			@(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire
